// File: verification/stimulus_input.txt
# op addr data lanes expect: op W write, R read and check, I hold AS_N with no DTACK_N
# addr is the byte address in hex, lanes 2 = upper, 1 = lower, expect is the readback
R FF820A 0000 2 FDFF
W FF820A 0200 2 0000
R FF820A 0000 2 FFFF
W FF820A 0000 2 0000
R FF820A 0000 2 FDFF
W FF8260 0100 2 0000
R FF8260 0000 2 FDFF
W FF8260 0000 2 0000
R FF8260 0000 2 FCFF
W FF8201 00AB 1 0000
R FF8201 0000 1 FFEB
W FF8203 125A 1 0000
R FF8203 0000 1 FF5A
W FF820D 00A5 1 0000
R FF820D 0000 1 FFA4
W FF820D 0011 1 0000
R FF820D 0000 1 FF10
I FF8240 0000 3 0000
I FF8201 0000 2 0000

// File: compile.f
+incdir+source
source/gstmcu_pkg.sv
source/bus_decoder.sv
source/video_regs.sv
source/sync_gen.sv
source/de_gen.sv
source/gstmcu_video.sv
verification/tb_clock_gen.sv
verification/tb_gstmcu_video.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the video timing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tb_gstmcu_video -o sim_gstmcu_video
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_gstmcu_video)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -Fqx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// File: verification/tb_gstmcu_video.sv
`timescale 1ns/1ns
`default_nettype none
`include "gstmcu_cfg.svh"

module tb_gstmcu_video;

    localparam int DTACK_WAIT = 16;
    localparam int FRAME_PAL  = `TICK_DIV * `LINE_TICKS_PAL * `FRAME_LINES_PAL;
    localparam int HDE_CYCLES = `TICK_DIV * (`HDE_END_PAL - `HDE_START_PAL);
    localparam int VDE_LINES  = `VDE_END_PAL - `VDE_START_PAL;
    localparam int HBL_CYCLES = `TICK_DIV * (`HBLANK_END_PAL - `HBLANK_START_PAL);
    localparam int VBL_LINES  = `VBLANK_END_PAL - `VBLANK_START_PAL;

    logic        clk32;
    logic        porb;
    logic        as_n  = 1'b1;
    logic        rw    = 1'b1;
    logic        uds_n = 1'b1;
    logic        lds_n = 1'b1;
    logic [23:1] a     = '0;
    logic [15:0] din   = '0;
    logic [15:0] dout;
    logic        dtack_n, berr_n, hsync_n, vsync_n, de, blank_n;

    int cycle  = 0;   // clk32 edges since time 0
    int errors = 0;
    int tests  = 0;
    int failed = 0;

    tb_clock_gen u_clk (.clk32(clk32), .porb(porb));

    gstmcu_video dut0 (
        .clk32(clk32), .porb(porb), .as_n_i(as_n), .rw_i(rw), .uds_n_i(uds_n),
        .lds_n_i(lds_n), .a_i(a), .din_i(din), .dout_o(dout), .dtack_n_o(dtack_n),
        .berr_n_o(berr_n), .hsync_n_o(hsync_n), .vsync_n_o(vsync_n), .de_o(de),
        .blank_n_o(blank_n)
    );

    always @(posedge clk32) cycle <= cycle + 1;

    function automatic logic probe(input int which);
        case (which)
            0:       probe = hsync_n;
            1:       probe = vsync_n;
            default: probe = de;
        endcase
    endfunction

    function automatic string sig_name(input int which);
        case (which)
            0:       sig_name = "hsync_n_o";
            1:       sig_name = "vsync_n_o";
            default: sig_name = "de_o";
        endcase
    endfunction

    task automatic check_eq(input string sig, input logic [31:0] got,
                            input logic [31:0] expv, input logic hex);
        assert (got == expv) else begin
            if (hex)
                $display("MISMATCH at %0t ns: %s expected %0h got %0h", $time, sig, expv, got);
            else
                $display("MISMATCH at %0t ns: %s expected %0d got %0d", $time, sig, expv, got);
            errors++;
        end
    endtask

    task automatic end_test(input string title, input int mark);
        tests++;
        if (errors == mark) begin
            $display("test %0d %s: ok", tests, title);
        end else begin
            failed++;
            $display("test %0d %s: FAILED", tests, title);
        end
    endtask

    // Stamp the cycle where a timing output moves to level
    task automatic wait_level(input int which, input logic level, input int limit,
                              output int stamp);
        int   n;
        logic prev;
        @(negedge clk32);
        prev  = probe(which);
        n     = 0;
        stamp = -1;
        while (stamp < 0 && n < limit) begin
            @(negedge clk32);
            n++;
            if (probe(which) == level && prev != level)
                stamp = cycle;
            prev = probe(which);
        end
        assert (stamp >= 0) else begin
            $display("Timeout at %0t ns: %s did not go to %0b within %0d cycles",
                     $time, sig_name(which), level, limit);
            errors++;
        end
    endtask

    task automatic release_bus();
        int n;
        int gap;
        @(posedge clk32);
        as_n  <= 1'b1;
        uds_n <= 1'b1;
        lds_n <= 1'b1;
        rw    <= 1'b1;
        n = 0;
        do begin
            @(negedge clk32);
            n++;
        end while ((!dtack_n || !berr_n) && n < 8);
        assert (dtack_n && berr_n) else begin
            $display("DTACK_N or BERR_N still low %0d cycles after AS_N went high", n);
            errors++;
        end
        gap = $urandom % 5;
        repeat (gap) @(posedge clk32);
    endtask

    task automatic bus_cycle(input logic write, input logic [23:0] addr,
                             input logic [15:0] data, input logic [1:0] lanes,
                             input logic [15:0] expv, input logic check_read);
        int   n;
        logic acked;
        @(posedge clk32);
        a     <= addr[23:1];
        din   <= data;
        rw    <= ~write;
        uds_n <= ~lanes[1];
        lds_n <= ~lanes[0];
        as_n  <= 1'b0;
        n     = 0;
        acked = 1'b0;
        while (!acked && n < DTACK_WAIT) begin
            @(negedge clk32);
            n++;
            acked = ~dtack_n;
        end
        assert (acked) else begin
            $display("No DTACK_N for access to %06h within %0d cycles", addr, DTACK_WAIT);
            errors++;
        end
        if (acked && check_read)
            check_eq("dout_o", 32'(dout), 32'(expv), 1'b1);
        release_bus();
    endtask

    // Strobe held on a dead address until the bus error fires
    task automatic hold_bus(input logic [23:0] addr, input logic [1:0] lanes);
        int   n;
        logic acked;
        @(posedge clk32);
        a     <= addr[23:1];
        rw    <= 1'b1;
        uds_n <= ~lanes[1];
        lds_n <= ~lanes[0];
        as_n  <= 1'b0;
        n     = 0;
        acked = 1'b0;
        do begin
            @(negedge clk32);
            n++;
            if (!dtack_n)
                acked = 1'b1;
        end while (berr_n && n < `BERR_LIMIT + 64);
        assert (!acked) else begin
            $display("DTACK_N answered the unmapped access to %06h", addr);
            errors++;
        end
        assert (!berr_n) else begin
            $display("No BERR_N after %0d cycles of address strobe", n);
            errors++;
        end
        assert (berr_n || (n >= `BERR_LIMIT && n <= `BERR_LIMIT + 4)) else begin
            $display("MISMATCH at %0t ns: berr_n_o delay expected %0d..%0d got %0d",
                     $time, `BERR_LIMIT, `BERR_LIMIT + 4, n);
            errors++;
        end
        release_bus();
    endtask

    task automatic check_mode(input string title, input logic [15:0] sync_val,
                              input logic [15:0] mode_val, input int line_ticks);
        int s0, s1, r1, s2;
        int mark;
        int limit;
        mark  = errors;
        limit = 2 * `TICK_DIV * `LINE_TICKS_PAL + 64;
        bus_cycle(1'b1, 24'hFF820A, sync_val, 2'b10, 16'h0, 1'b0);
        bus_cycle(1'b1, 24'hFF8260, mode_val, 2'b10, 16'h0, 1'b0);
        wait_level(0, 1'b0, limit, s0);  // New mode runs from this line
        wait_level(0, 1'b0, limit, s1);
        wait_level(0, 1'b1, limit, r1);
        wait_level(0, 1'b0, limit, s2);
        check_eq("hsync_n_o period", s2 - s1, `TICK_DIV * line_ticks, 1'b0);
        check_eq("hsync_n_o low time", r1 - s1, `TICK_DIV * `HSYNC_TICKS, 1'b0);
        end_test(title, mark);
    endtask

    // One PAL frame, starting just after a vsync fall
    task automatic check_de_frame();
        int   n, rise, lines, bl_rise, bl_lines;
        logic de_prev, bl_prev, vs_prev, done;
        @(negedge clk32);
        de_prev  = de;
        bl_prev  = blank_n;
        vs_prev  = vsync_n;
        rise     = -1;
        bl_rise  = -1;
        lines    = 0;
        bl_lines = 0;
        n        = 0;
        done     = 1'b0;
        while (!done && n < FRAME_PAL + 64) begin
            @(negedge clk32);
            n++;
            if (de && !de_prev)
                rise = cycle;
            if (!de && de_prev && rise >= 0) begin
                lines++;
                check_eq("de_o high time", cycle - rise, HDE_CYCLES, 1'b0);
            end
            if (blank_n && !bl_prev)
                bl_rise = cycle;
            if (!blank_n && bl_prev && bl_rise >= 0) begin
                bl_lines++;
                check_eq("blank_n_o high time", cycle - bl_rise, HBL_CYCLES, 1'b0);
            end
            if (!vsync_n && vs_prev)
                done = 1'b1;
            de_prev = de;
            bl_prev = blank_n;
            vs_prev = vsync_n;
        end
        assert (done) else begin
            $display("Timeout: VSYNC_N did not fall again within one PAL frame");
            errors++;
        end
        check_eq("de_o active lines", lines, VDE_LINES, 1'b0);
        check_eq("blank_n_o active lines", bl_lines, VBL_LINES, 1'b0);
    endtask

    initial begin
        logic [31:0] f_addr, f_data, f_lanes, f_exp;
        string       line;
        byte         op;
        int          fd, n, mark, v0, v1;

        void'($urandom(31));
        n = 0;
        do begin
            @(negedge clk32);
            n++;
        end while (!porb && n < 64);

        mark = errors;
        assert (porb) else begin
            $display("Reset never released");
            errors++;
        end
        check_eq("dtack_n_o", 32'(dtack_n), 32'd1, 1'b0);
        check_eq("berr_n_o", 32'(berr_n), 32'd1, 1'b0);
        check_eq("hsync_n_o", 32'(hsync_n), 32'd1, 1'b0);
        check_eq("vsync_n_o", 32'(vsync_n), 32'd1, 1'b0);
        check_eq("de_o", 32'(de), 32'd0, 1'b0);
        end_test("reset state", mark);

        fd = $fopen("verification/stimulus_input.txt", "r");
        assert (fd != 0) else begin
            $display("Cannot open the stimulus file");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#")
                continue;
            mark = errors;
            n = $sscanf(line, "%c %h %h %h %h", op, f_addr, f_data, f_lanes, f_exp);
            if (n != 5) begin
                $display("Malformed stimulus line: %s", line);
                errors++;
            end else begin
                case (op)
                    "W": bus_cycle(1'b1, f_addr[23:0], f_data[15:0], f_lanes[1:0],
                                   f_exp[15:0], 1'b0);
                    "R": bus_cycle(1'b0, f_addr[23:0], f_data[15:0], f_lanes[1:0],
                                   f_exp[15:0], 1'b1);
                    "I": hold_bus(f_addr[23:0], f_lanes[1:0]);
                    default: begin
                        $display("Unknown operation in stimulus line: %s", line);
                        errors++;
                    end
                endcase
            end
            end_test($sformatf("%c %06h", op, f_addr[23:0]), mark);
        end
        if (fd != 0)
            $fclose(fd);

        check_mode("NTSC line timing", 16'h0000, 16'h0000, `LINE_TICKS_NTSC);
        check_mode("mono line timing", 16'h0000, 16'h0200, `LINE_TICKS_MONO);
        check_mode("PAL line timing", 16'h0200, 16'h0000, `LINE_TICKS_PAL);

        mark = errors;
        wait_level(1, 1'b0, 2 * FRAME_PAL + 64, v0);
        wait_level(1, 1'b0, FRAME_PAL + 64, v1);
        check_eq("vsync_n_o period", v1 - v0, FRAME_PAL, 1'b0);
        end_test("PAL frame period", mark);

        mark = errors;
        check_de_frame();
        end_test("PAL display enable and blanking", mark);

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk32,
    output logic porb
);

    // 4 ns period
    always begin
        clk32 = 1'b0;
        #2;
        clk32 = 1'b1;
        #2;
    end

    initial begin
        porb <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk32);
        porb <= 1'b1;
    end

endmodule

`default_nettype wire

// File: source/gstmcu_video.sv
`timescale 1ns/1ns
`default_nettype none

module gstmcu_video import gstmcu_pkg::*; (
    input  wire logic        clk32,
    input  wire logic        porb,
    input  wire logic        as_n_i,
    input  wire logic        rw_i,
    input  wire logic        uds_n_i,
    input  wire logic        lds_n_i,
    input  wire logic [23:1] a_i,
    input  wire logic [15:0] din_i,
    output logic [15:0]      dout_o,
    output logic             dtack_n_o,
    output logic             berr_n_o,
    output logic             hsync_n_o,
    output logic             vsync_n_o,
    output logic             de_o,
    output logic             blank_n_o
);

    cpu_bus_t    cpu_bus;
    reg_access_t reg_access;
    video_mode_t reg_mode, line_mode;
    beam_pos_t   beam;
    logic        tick;

    assign cpu_bus = '{addr: a_i, wdata: din_i, rw: rw_i};

    bus_decoder u_dec (.clk32, .porb, .cpu_bus_i(cpu_bus), .as_n_i, .uds_n_i, .lds_n_i,
                       .reg_access_o(reg_access), .dtack_n_o, .berr_n_o);

    video_regs u_regs (.clk32, .porb, .reg_access_i(reg_access), .wdata_i(cpu_bus.wdata),
                       .rdata_o(dout_o), .mode_o(reg_mode));

    // Timing runs on the per-line mode from the sync generator
    sync_gen u_sync (.clk32, .porb, .mode_i(reg_mode), .beam_o(beam),
                     .line_mode_o(line_mode), .tick_o(tick), .hsync_n_o, .vsync_n_o);

    de_gen u_de (.clk32, .porb, .tick_i(tick), .beam_i(beam), .mode_i(line_mode),
                 .de_o, .blank_n_o);

endmodule

`default_nettype wire

// File: source/de_gen.sv
`timescale 1ns/1ns
`default_nettype none
`include "gstmcu_cfg.svh"

module de_gen import gstmcu_pkg::*; (
    input  wire logic        clk32,
    input  wire logic        porb,
    input  wire logic        tick_i,
    input  wire beam_pos_t   beam_i,
    input  wire video_mode_t mode_i,
    output logic             de_o,
    output logic             blank_n_o
);

    logic [7:0] hde_on, hde_off, hbl_on, hbl_off;
    logic [8:0] vde_on, vde_off, vbl_on, vbl_off;
    logic       blank_en;   // No blanking in mono
    logic       hde, hblank, vde, vblank;

    always_comb begin
        case (mode_i)
            MODE_PAL: begin
                {hde_on, hde_off} = {8'(`HDE_START_PAL), 8'(`HDE_END_PAL)};
                {hbl_on, hbl_off} = {8'(`HBLANK_START_PAL), 8'(`HBLANK_END_PAL)};
                {vde_on, vde_off} = {9'(`VDE_START_PAL), 9'(`VDE_END_PAL)};
                {vbl_on, vbl_off} = {9'(`VBLANK_START_PAL), 9'(`VBLANK_END_PAL)};
                blank_en          = 1'b1;
            end
            MODE_MONO: begin
                {hde_on, hde_off} = {8'(`HDE_START_MONO), 8'(`HDE_END_MONO)};
                {hbl_on, hbl_off} = 16'd0;
                {vde_on, vde_off} = {9'(`VDE_START_MONO), 9'(`VDE_END_MONO)};
                {vbl_on, vbl_off} = 18'd0;
                blank_en          = 1'b0;
            end
            default: begin
                {hde_on, hde_off} = {8'(`HDE_START_NTSC), 8'(`HDE_END_NTSC)};
                {hbl_on, hbl_off} = {8'(`HBLANK_START_NTSC), 8'(`HBLANK_END_NTSC)};
                {vde_on, vde_off} = {9'(`VDE_START_NTSC), 9'(`VDE_END_NTSC)};
                {vbl_on, vbl_off} = {9'(`VBLANK_START_NTSC), 9'(`VBLANK_END_NTSC)};
                blank_en          = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            {hde, hblank, vde, vblank} <= 4'b0;
            de_o      <= 1'b0;
            blank_n_o <= 1'b1;
        end else if (tick_i) begin
            if (beam_i.hcount == hde_on)  hde <= 1'b1;
            if (beam_i.hcount == hde_off) hde <= 1'b0; // End wins on a clash
            if (blank_en && beam_i.hcount == hbl_on) hblank <= 1'b1;
            if (!blank_en || beam_i.hcount == hbl_off) hblank <= 1'b0;

            // Vertical windows move once per line
            if (beam_i.line_start) begin
                if (beam_i.vcount == vde_on)  vde <= 1'b1;
                if (beam_i.vcount == vde_off) vde <= 1'b0;
                if (blank_en && beam_i.vcount == vbl_on) vblank <= 1'b1;
                if (!blank_en || beam_i.vcount == vbl_off) vblank <= 1'b0;
            end

            de_o      <= hde & vde;
            blank_n_o <= ~blank_en | (hblank & vblank);
        end
    end

endmodule

`default_nettype wire

// File: source/sync_gen.sv
`timescale 1ns/1ns
`default_nettype none
`include "gstmcu_cfg.svh"

module sync_gen import gstmcu_pkg::*; (
    input  wire logic        clk32,
    input  wire logic        porb,
    input  wire video_mode_t mode_i,
    output beam_pos_t        beam_o,
    output video_mode_t      line_mode_o,
    output logic             tick_o,
    output logic             hsync_n_o,
    output logic             vsync_n_o
);

    localparam int DW = $clog2(`TICK_DIV);

    logic [DW-1:0] div_q;
    logic          tick;
    logic [7:0]    hcount, line_last;
    logic [8:0]    vcount, frame_last;
    video_mode_t   line_mode;
    logic          hsync_q, vsync_q;

    assign tick = div_q == DW'(`TICK_DIV - 1);

    // Wrap values follow the mode latched for this line
    always_comb begin
        case (line_mode)
            MODE_PAL: begin
                line_last  = 8'(`LINE_TICKS_PAL - 1);
                frame_last = 9'(`FRAME_LINES_PAL - 1);
            end
            MODE_MONO: begin
                line_last  = 8'(`LINE_TICKS_MONO - 1);
                frame_last = 9'(`FRAME_LINES_MONO - 1);
            end
            default: begin
                line_last  = 8'(`LINE_TICKS_NTSC - 1);
                frame_last = 9'(`FRAME_LINES_NTSC - 1);
            end
        endcase
    end

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            div_q     <= '0;
            hcount    <= '0;
            vcount    <= '0;
            line_mode <= MODE_NTSC;
            hsync_q   <= 1'b1;
            vsync_q   <= 1'b1;
        end else begin
            div_q <= tick ? '0 : div_q + 1'b1;
            if (tick) begin
                if (hcount == line_last) begin
                    hcount    <= '0;
                    line_mode <= mode_i; // Mode only changes between lines
                    hsync_q   <= 1'b0;
                    if (vcount >= frame_last) begin
                        vcount  <= '0;
                        vsync_q <= 1'b0;
                    end else begin
                        vcount <= vcount + 1'b1;
                        if (vcount == 9'(`VSYNC_LINES - 1))
                            vsync_q <= 1'b1;
                    end
                end else begin
                    hcount <= hcount + 1'b1;
                    if (hcount == 8'(`HSYNC_TICKS - 1))
                        hsync_q <= 1'b1;
                end
            end
        end
    end

    assign beam_o      = '{hcount: hcount, vcount: vcount, line_start: hcount == 8'd0};
    assign line_mode_o = line_mode;
    assign tick_o      = tick;
    assign hsync_n_o   = hsync_q;
    assign vsync_n_o   = vsync_q;

endmodule

`default_nettype wire

// File: source/video_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "gstmcu_cfg.svh"

module video_regs import gstmcu_pkg::*; (
    input  wire logic        clk32,
    input  wire logic        porb,
    input  wire reg_access_t reg_access_i,
    input  wire logic [15:0] wdata_i,
    output logic [15:0]      rdata_o,
    output video_mode_t      mode_o
);

    logic       pal;
    logic       mde1, mde0;
    logic [5:0] vb_hi;
    logic [7:0] vb_mid;
    logic [6:0] vb_lo;   // Address bits 7:1
    logic [7:0] wbyte;
    logic [7:0] rbyte;
    logic       wr;

    // Pick the byte lane the register lives on
    assign wbyte = reg_access_i.upper ? wdata_i[15:8] : wdata_i[7:0];
    assign wr    = reg_access_i.stb & reg_access_i.write;

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            pal    <= 1'b0;
            mde1   <= 1'b0;
            mde0   <= 1'b0;
            vb_hi  <= '0;
            vb_mid <= '0;
            vb_lo  <= '0;
        end else if (wr) begin
            if (reg_access_i.sel[SEL_SYNC])   pal    <= wbyte[1]; // D9
            if (reg_access_i.sel[SEL_MODE])   {mde1, mde0} <= wbyte[1:0];
            if (reg_access_i.sel[SEL_VB_HI])  vb_hi  <= wbyte[5:0];
            if (reg_access_i.sel[SEL_VB_MID]) vb_mid <= wbyte;
            if (reg_access_i.sel[SEL_VB_LO])  vb_lo  <= wbyte[7:1];
        end
    end

    // Readback, unused bits float high
    always_comb begin
        rbyte = 8'hFF;
        if (!reg_access_i.write) begin
            if (reg_access_i.sel[SEL_SYNC])   rbyte = {6'h3F, pal, 1'b1};
            if (reg_access_i.sel[SEL_MODE])   rbyte = {6'h3F, mde1, mde0};
            if (reg_access_i.sel[SEL_VB_HI])  rbyte = {2'b11, vb_hi};
            if (reg_access_i.sel[SEL_VB_MID]) rbyte = vb_mid;
            if (reg_access_i.sel[SEL_VB_LO])  rbyte = {vb_lo, 1'b0};
        end
    end

    assign rdata_o = reg_access_i.upper ? {rbyte, 8'hFF} : {8'hFF, rbyte};

    // Mono overrides the colour standard
    always_comb begin
        if (mde1)
            mode_o = MODE_MONO;
        else if (pal)
            mode_o = MODE_PAL;
        else
            mode_o = MODE_NTSC;
    end

endmodule

`default_nettype wire

// File: source/bus_decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "gstmcu_cfg.svh"

module bus_decoder import gstmcu_pkg::*; (
    input  wire logic     clk32,
    input  wire logic     porb,
    input  wire cpu_bus_t cpu_bus_i,
    input  wire logic     as_n_i,
    input  wire logic     uds_n_i,
    input  wire logic     lds_n_i,
    output reg_access_t   reg_access_o,
    output logic          dtack_n_o,
    output logic          berr_n_o
);

    localparam int BW = $clog2(`BERR_LIMIT + 1);

    logic          as_s1, as_s2, as_d;
    logic          as_act, as_fall;
    logic          ff_page;
    logic [14:0]   word;
    logic [4:0]    sel_hit;
    logic          stb_q, dtack_q;
    logic [BW-1:0] berr_cnt;

    assign as_act  = ~as_s2;
    assign as_fall = ~as_s2 & as_d;

    assign ff_page = cpu_bus_i.addr[22:15] == 8'hFF;
    assign word    = cpu_bus_i.addr[14:0];

    // Sync and mode sit on the upper byte, video base on the lower
    assign sel_hit[SEL_SYNC]   = ff_page & ~uds_n_i & (word == `REG_SYNC);
    assign sel_hit[SEL_MODE]   = ff_page & ~uds_n_i & (word == `REG_MODE);
    assign sel_hit[SEL_VB_HI]  = ff_page & ~lds_n_i & (word == `REG_VBASE_HI);
    assign sel_hit[SEL_VB_MID] = ff_page & ~lds_n_i & (word == `REG_VBASE_MID);
    assign sel_hit[SEL_VB_LO]  = ff_page & ~lds_n_i & (word == `REG_VBASE_LO);

    assign reg_access_o.sel   = as_act ? sel_hit : 5'b0;
    assign reg_access_o.stb   = stb_q;
    assign reg_access_o.write = ~cpu_bus_i.rw;
    assign reg_access_o.upper = sel_hit[SEL_SYNC] | sel_hit[SEL_MODE];

    assign dtack_n_o = ~dtack_q;
    assign berr_n_o  = ~(berr_cnt == BW'(`BERR_LIMIT));

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            as_s1    <= 1'b1;
            as_s2    <= 1'b1;
            as_d     <= 1'b1;
            stb_q    <= 1'b0;
            dtack_q  <= 1'b0;
            berr_cnt <= '0;
        end else begin
            as_s1 <= as_n_i;
            as_s2 <= as_s1;
            as_d  <= as_s2;
            stb_q <= as_fall & |sel_hit; // Two cycles after AS_N seen low

            if (as_s2)
                dtack_q <= 1'b0;
            else if (stb_q)
                dtack_q <= 1'b1;

            // Bus error timeout, saturates at the limit
            if (as_s2)
                berr_cnt <= '0;
            else if (berr_cnt != BW'(`BERR_LIMIT))
                berr_cnt <= berr_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/gstmcu_pkg.sv
`default_nettype none

package gstmcu_pkg;

    // CPU pins as seen by the decoder, addr is A[23:1]
    typedef struct packed {
        logic [22:0] addr;
        logic [15:0] wdata;
        logic        rw;     // High for read
    } cpu_bus_t;

    // Bit positions in the one-hot select
    localparam int SEL_SYNC   = 0;
    localparam int SEL_MODE   = 1;
    localparam int SEL_VB_HI  = 2;
    localparam int SEL_VB_MID = 3;
    localparam int SEL_VB_LO  = 4;

    typedef struct packed {
        logic [4:0] sel;     // Held while AS_N is low
        logic       stb;     // Single cycle
        logic       write;
        logic       upper;   // Register lives on D15..D8
    } reg_access_t;

    typedef enum logic [1:0] {
        MODE_NTSC = 2'd0,
        MODE_PAL  = 2'd1,
        MODE_MONO = 2'd2
    } video_mode_t;

    typedef struct packed {
        logic [7:0] hcount;
        logic [8:0] vcount;
        logic       line_start;
    } beam_pos_t;

endpackage

`default_nettype wire

// File: source/gstmcu_cfg.svh
`ifndef GSTMCU_CFG_SVH
`define GSTMCU_CFG_SVH

// Bus error after this many clk32 cycles of address strobe
`define BERR_LIMIT        256

// Pixel tick is clk32 / 16, about 2 MHz
`define TICK_DIV          16

`define LINE_TICKS_PAL    128
`define LINE_TICKS_NTSC   127
`define LINE_TICKS_MONO   56
`define HSYNC_TICKS       10

`define FRAME_LINES_PAL   313
`define FRAME_LINES_NTSC  263
`define FRAME_LINES_MONO  501
`define VSYNC_LINES       3

// Horizontal windows in ticks
`define HDE_START_PAL     12
`define HDE_END_PAL       96
`define HDE_START_NTSC    11
`define HDE_END_NTSC      93
`define HDE_START_MONO    2
`define HDE_END_MONO      43
`define HBLANK_START_PAL  9
`define HBLANK_END_PAL    114
`define HBLANK_START_NTSC 8
`define HBLANK_END_NTSC   114

// Vertical windows in lines
`define VDE_START_PAL     62
`define VDE_END_PAL       262
`define VDE_START_NTSC    33
`define VDE_END_NTSC      233
`define VDE_START_MONO    35
`define VDE_END_MONO      435
`define VBLANK_START_PAL  24
`define VBLANK_END_PAL    307
`define VBLANK_START_NTSC 15
`define VBLANK_END_NTSC   257

// Word addresses A[15:1] in the FF page
`define REG_SYNC          15'h4105 // FF820A
`define REG_MODE          15'h4130 // FF8260
`define REG_VBASE_HI      15'h4100 // FF8201
`define REG_VBASE_MID     15'h4101 // FF8203
`define REG_VBASE_LO      15'h4106 // FF820D

`endif
